/* hdl/fpu_afu_settings.svh */
`ifndef FPU_AFU_SETTINGS_SVH
`define FPU_AFU_SETTINGS_SVH

// One host cache line, also the width of both requester data buses
`define LINE_BITS 512

// Software hands over 64-bit virtual byte addresses
`define HOST_ADDR_BITS 64

// Requesters address host memory in whole lines
`define CPU_ADDR_BITS 32

// MMIO register window
`define MMIO_ADDR_BITS 16
`define MMIO_DATA_BITS 64

// Constant accelerator ID, read back by software to find the AFU
`define AFU_ID_LO 64'h9c4e_27d1_b0a5_3f68
`define AFU_ID_HI 64'h5e1a_73c2_d84f_0b96

// Register word offsets
`define REG_ID_LO 0
`define REG_ID_HI 1
`define REG_BASE 2
`define REG_GO 3
`define REG_COUNT 4

`endif

/* hdl/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  // ******************************
  // Memory operations
  // ******************************

  // Operation a requester puts on its op port
  // A requester shows mem_idle whenever it has nothing pending
  typedef enum logic [1:0] {
    mem_idle  = 2'd0,
    mem_read  = 2'd1,
    mem_write = 2'd2
  } mem_op_e;

  // Index of the requester that owns the controller
  typedef logic src_id_t;

  // The instruction-fetch port
  localparam src_id_t SRC_FE = 1'b0;
  // The data port
  localparam src_id_t SRC_ME = 1'b1;

endpackage

`default_nettype wire

/* hdl/mmio_pkg.sv */
`default_nettype none

`include "fpu_afu_settings.svh"

package mmio_pkg;

  // Register address and data as they appear on the MMIO pins
  typedef logic [`MMIO_ADDR_BITS-1:0] mmio_addr_t;
  typedef logic [`MMIO_DATA_BITS-1:0] mmio_data_t;

  // Decoded register, sel_none for any offset outside the map
  typedef enum logic [2:0] {
    sel_id_lo,
    sel_id_hi,
    sel_base,
    sel_go,
    sel_count,
    sel_none
  } reg_sel_e;

  // Turns an MMIO word offset into a register selector
  function automatic reg_sel_e decode_reg(mmio_addr_t addr);
    reg_sel_e sel;
    case (addr)
      `REG_ID_LO: sel = sel_id_lo;
      `REG_ID_HI: sel = sel_id_hi;
      `REG_BASE:  sel = sel_base;
      `REG_GO:    sel = sel_go;
      `REG_COUNT: sel = sel_count;
      default:    sel = sel_none;
    endcase
    return sel;
  endfunction

endpackage

`default_nettype wire

/* hdl/mmio_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpu_afu_settings.svh"

module mmio_regs (
  input  wire logic                         clk,
  input  wire logic                         reset,

  // MMIO pins driven by the host
  input  wire logic                         mmio_wr_en,
  input  wire logic                         mmio_rd_en,
  input  wire mmio_pkg::mmio_addr_t         mmio_addr,
  input  wire mmio_pkg::mmio_data_t         mmio_wr_data,
  output mmio_pkg::mmio_data_t              mmio_rd_data,
  output logic                              mmio_rd_valid,

  // One pulse per finished line transfer
  input  wire logic                         tx_done,

  // Configuration seen by the memory controller
  output logic [`HOST_ADDR_BITS-1:0]        base_addr,
  output logic                              enable
);

  import mmio_pkg::*;

  // Register addressed by the current access
  reg_sel_e   sel;
  // Completed transfers since reset
  mmio_data_t count;

  assign sel = decode_reg(mmio_addr);

  // ******************************
  // Writable state
  // ******************************

  always_ff @(posedge clk) begin
    if (reset) begin
      base_addr     <= '0;
      enable        <= 1'b0;
      count         <= '0;
      mmio_rd_valid <= 1'b0;
    end else begin
      // Read data always follows the request by exactly one cycle
      mmio_rd_valid <= mmio_rd_en;

      if (mmio_wr_en && (sel == sel_base)) begin
        base_addr <= mmio_wr_data;
      end

      // Enable is sticky, only reset takes it away again
      if (mmio_wr_en && (sel == sel_go)) begin
        enable <= 1'b1;
      end

      if (tx_done) begin
        count <= count + 1'b1;
      end
    end
  end

  // ******************************
  // Read path
  // ******************************

  // The data register only changes on a read, so it holds between reads
  always_ff @(posedge clk) begin
    if (mmio_rd_en) begin
      case (sel)
        sel_id_lo: mmio_rd_data <= `AFU_ID_LO;
        sel_id_hi: mmio_rd_data <= `AFU_ID_HI;
        sel_base:  mmio_rd_data <= base_addr;
        // The go register reads back whether the enable latch is set
        sel_go:    mmio_rd_data <= {{(`MMIO_DATA_BITS-1){1'b0}}, enable};
        sel_count: mmio_rd_data <= count;
        default:   mmio_rd_data <= '0;
      endcase
    end
  end

  // The host issues one access per cycle, never a read and a write together
  a_no_rd_wr_collision: assert property (
    @(posedge clk) disable iff (reset)
      !(mmio_rd_en && mmio_wr_en)
  );

endmodule

`default_nettype wire

/* hdl/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpu_afu_settings.svh"

module mem_arbiter (
  input  wire logic                     clk,
  input  wire logic                     reset,

  // Instruction-fetch requester
  input  wire mem_pkg::mem_op_e         fe_op,
  input  wire logic [`CPU_ADDR_BITS-1:0] fe_addr,
  input  wire logic [`LINE_BITS-1:0]    fe_wr_line,
  output logic [`LINE_BITS-1:0]         fe_rd_line,
  output logic                          fe_rd_valid,
  output logic                          fe_tx_done,

  // Data requester
  input  wire mem_pkg::mem_op_e         me_op,
  input  wire logic [`CPU_ADDR_BITS-1:0] me_addr,
  input  wire logic [`LINE_BITS-1:0]    me_wr_line,
  output logic [`LINE_BITS-1:0]         me_rd_line,
  output logic                          me_rd_valid,
  output logic                          me_tx_done,

  // Responses from the memory controller
  input  wire logic                     ready,
  input  wire logic                     tx_done,
  input  wire logic                     rd_valid,
  input  wire logic [`LINE_BITS-1:0]    rd_line,

  // Request forwarded to the memory controller
  output mem_pkg::mem_op_e              op,
  output logic [`CPU_ADDR_BITS-1:0]     addr,
  output logic [`LINE_BITS-1:0]         wr_line
);

  import mem_pkg::*;

  // High from acceptance until the controller reports tx_done
  logic    busy;
  // Last source granted, which is also the owner while busy
  src_id_t last_grant;
  // Source chosen this cycle if nothing is in flight
  src_id_t pick;
  // Source whose fields go to the controller
  src_id_t cur_src;
  logic    fe_req;
  logic    me_req;
  logic    any_req;
  logic    fe_owns;
  logic    me_owns;

  assign fe_req  = (fe_op != mem_idle);
  assign me_req  = (me_op != mem_idle);
  assign any_req = fe_req || me_req;

  // ******************************
  // Round-robin choice
  // ******************************

  // On a tie the source that was not served last wins
  always_comb begin
    if (fe_req && me_req) begin
      pick = ~last_grant;
    end else if (me_req) begin
      pick = SRC_ME;
    end else begin
      pick = SRC_FE;
    end
  end

  // Grant is committed on the same edge the controller accepts the request,
  // both see ready high and a request that is not idle
  always_ff @(posedge clk) begin
    if (reset) begin
      busy       <= 1'b0;
      // Fetch wins the first tie after reset
      last_grant <= SRC_ME;
    end else if (busy) begin
      if (tx_done) begin
        busy <= 1'b0;
      end
    end else if (ready && any_req) begin
      busy       <= 1'b1;
      last_grant <= pick;
    end
  end

  // While idle the live choice is forwarded so no cycle is lost
  assign cur_src = busy ? last_grant : pick;

  // ******************************
  // Request and response steering
  // ******************************

  assign op      = (cur_src == SRC_ME) ? me_op      : fe_op;
  assign addr    = (cur_src == SRC_ME) ? me_addr    : fe_addr;
  assign wr_line = (cur_src == SRC_ME) ? me_wr_line : fe_wr_line;

  assign fe_owns = busy && (last_grant == SRC_FE);
  assign me_owns = busy && (last_grant == SRC_ME);

  // The source that is not served sees a quiet response bus
  assign fe_rd_line  = fe_owns ? rd_line : '0;
  assign fe_rd_valid = fe_owns && rd_valid;
  assign fe_tx_done  = fe_owns && tx_done;

  assign me_rd_line  = me_owns ? rd_line : '0;
  assign me_rd_valid = me_owns && rd_valid;
  assign me_tx_done  = me_owns && tx_done;

  // While a transfer is in flight the controller must not offer to take another
  // A second request would otherwise slip in under the grant that is still open
  a_busy_not_ready: assert property (
    @(posedge clk) disable iff (reset)
      busy |-> !ready
  );

  // The controller only finishes transfers that this arbiter handed it
  a_done_while_busy: assert property (
    @(posedge clk) disable iff (reset)
      tx_done |-> busy
  );

endmodule

`default_nettype wire

/* hdl/mem_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpu_afu_settings.svh"

module mem_ctrl (
  input  wire logic                      clk,
  input  wire logic                      reset,

  // Configuration from the register block
  input  wire logic                      enable,
  input  wire logic [`HOST_ADDR_BITS-1:0] base_addr,

  // Request from the arbiter
  input  wire mem_pkg::mem_op_e          op,
  input  wire logic [`CPU_ADDR_BITS-1:0]  addr,
  input  wire logic [`LINE_BITS-1:0]     wr_line,

  // Status and response back to the arbiter
  output logic                           ready,
  output logic [`LINE_BITS-1:0]          rd_line,
  output logic                           rd_valid,
  output logic                           tx_done,

  // DMA port towards host memory
  input  wire logic                      dma_empty,
  input  wire logic                      dma_full,
  input  wire logic [`LINE_BITS-1:0]     dma_rd_data,
  output logic                           dma_rd_go,
  output logic                           dma_wr_go,
  output logic                           dma_rd_en,
  output logic                           dma_wr_en,
  output logic [`HOST_ADDR_BITS-1:0]     dma_rd_addr,
  output logic [`HOST_ADDR_BITS-1:0]     dma_wr_addr,
  output logic [`LINE_BITS-1:0]          dma_wr_data
);

  import mem_pkg::*;

  // Byte offset of one line is the line index shifted by log2 of line bytes
  localparam int LINE_SHIFT = $clog2(`LINE_BITS / 8);
  localparam int PAD_BITS   = `HOST_ADDR_BITS - `CPU_ADDR_BITS - LINE_SHIFT;

  typedef enum logic [1:0] {
    st_idle,
    st_go,
    st_xfer,
    st_done
  } state_e;

  state_e                     state;
  // Operation of the transfer in flight
  mem_op_e                    cur_op;
  // Host byte address of the line in flight
  logic [`HOST_ADDR_BITS-1:0] host_addr;
  // Requester line offset turned into a byte offset
  logic [`HOST_ADDR_BITS-1:0] line_byte_addr;
  // Write payload captured on acceptance
  logic [`LINE_BITS-1:0]      wr_buf;
  logic                       accept;

  assign line_byte_addr = {{PAD_BITS{1'b0}}, addr, {LINE_SHIFT{1'b0}}};

  // Only an idle controller that software has started takes new work
  assign ready  = enable && (state == st_idle);
  assign accept = ready && (op != mem_idle);

  // ******************************
  // Transfer sequencer
  // ******************************

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= st_idle;
      cur_op <= mem_idle;
    end else begin
      case (state)
        st_idle: begin
          if (accept) begin
            state  <= st_go;
            cur_op <= op;
          end
        end
        // One cycle to start the DMA channel
        st_go: begin
          state <= st_xfer;
        end
        // Wait here as long as the FIFO holds us back
        st_xfer: begin
          if (dma_rd_en || dma_wr_en) begin
            state <= st_done;
          end
        end
        st_done: begin
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Address and write line are sampled once, then held through any stall
  always_ff @(posedge clk) begin
    if (accept) begin
      host_addr <= base_addr + line_byte_addr;
      wr_buf    <= wr_line;
    end
  end

  // The FIFO head is valid while not empty, so take it with the pop
  always_ff @(posedge clk) begin
    if (dma_rd_en) begin
      rd_line <= dma_rd_data;
    end
  end

  // ******************************
  // DMA strobes
  // ******************************

  assign dma_rd_go = (state == st_go) && (cur_op == mem_read);
  assign dma_wr_go = (state == st_go) && (cur_op == mem_write);

  // Pop a line only when the read FIFO has one
  assign dma_rd_en = (state == st_xfer) && (cur_op == mem_read) && !dma_empty;
  // Push the line only when the write FIFO has room
  assign dma_wr_en = (state == st_xfer) && (cur_op == mem_write) && !dma_full;

  // Both channels share one address, only the matching go makes it count
  assign dma_rd_addr = host_addr;
  assign dma_wr_addr = host_addr;
  assign dma_wr_data = wr_buf;

  // Read data and completion reach the requester in the same cycle
  assign rd_valid = (state == st_done) && (cur_op == mem_read);
  assign tx_done  = (state == st_done);

  // A popped line reaches the requester in the very next cycle
  a_rd_pop_then_done: assert property (
    @(posedge clk) disable iff (reset)
      dma_rd_en |=> (rd_valid && tx_done)
  );

  // A pushed line finishes the write in the next cycle without read data
  a_wr_push_then_done: assert property (
    @(posedge clk) disable iff (reset)
      dma_wr_en |=> (tx_done && !rd_valid)
  );

endmodule

`default_nettype wire

/* hdl/fpu_afu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpu_afu_settings.svh"

module fpu_afu_top (
  input  wire logic                      clk,
  input  wire logic                      reset,

  // MMIO pins
  input  wire logic                      mmio_wr_en,
  input  wire logic                      mmio_rd_en,
  input  wire mmio_pkg::mmio_addr_t      mmio_addr,
  input  wire mmio_pkg::mmio_data_t      mmio_wr_data,
  output mmio_pkg::mmio_data_t           mmio_rd_data,
  output logic                           mmio_rd_valid,

  // Instruction-fetch requester
  input  wire mem_pkg::mem_op_e          fe_op,
  input  wire logic [`CPU_ADDR_BITS-1:0]  fe_addr,
  input  wire logic [`LINE_BITS-1:0]     fe_wr_line,
  output logic [`LINE_BITS-1:0]          fe_rd_line,
  output logic                           fe_rd_valid,
  output logic                           fe_tx_done,

  // Data requester
  input  wire mem_pkg::mem_op_e          me_op,
  input  wire logic [`CPU_ADDR_BITS-1:0]  me_addr,
  input  wire logic [`LINE_BITS-1:0]     me_wr_line,
  output logic [`LINE_BITS-1:0]          me_rd_line,
  output logic                           me_rd_valid,
  output logic                           me_tx_done,

  // DMA pins towards host memory
  input  wire logic                      dma_empty,
  input  wire logic                      dma_full,
  input  wire logic [`LINE_BITS-1:0]     dma_rd_data,
  output logic                           dma_rd_go,
  output logic                           dma_wr_go,
  output logic                           dma_rd_en,
  output logic                           dma_wr_en,
  output logic [`HOST_ADDR_BITS-1:0]     dma_rd_addr,
  output logic [`HOST_ADDR_BITS-1:0]     dma_wr_addr,
  output logic [`LINE_BITS-1:0]          dma_wr_data
);

  import mem_pkg::*;

  // Configuration from the register block
  logic [`HOST_ADDR_BITS-1:0] base_addr;
  logic                       enable;

  // Controller status and response
  logic                       ready;
  logic                       tx_done;
  logic                       rd_valid;
  logic [`LINE_BITS-1:0]      rd_line;

  // Request chosen by the arbiter
  mem_op_e                    op;
  logic [`CPU_ADDR_BITS-1:0]  addr;
  logic [`LINE_BITS-1:0]      wr_line;

  // ******************************
  // Register block
  // ******************************

  mmio_regs i_mmio_regs (
    .clk           (clk),
    .reset         (reset),
    .mmio_wr_en    (mmio_wr_en),
    .mmio_rd_en    (mmio_rd_en),
    .mmio_addr     (mmio_addr),
    .mmio_wr_data  (mmio_wr_data),
    .mmio_rd_data  (mmio_rd_data),
    .mmio_rd_valid (mmio_rd_valid),
    .tx_done       (tx_done),
    .base_addr     (base_addr),
    .enable        (enable)
  );

  // Fetch and data ports share the controller
  mem_arbiter i_mem_arbiter (
    .clk         (clk),
    .reset       (reset),
    .fe_op       (fe_op),
    .fe_addr     (fe_addr),
    .fe_wr_line  (fe_wr_line),
    .fe_rd_line  (fe_rd_line),
    .fe_rd_valid (fe_rd_valid),
    .fe_tx_done  (fe_tx_done),
    .me_op       (me_op),
    .me_addr     (me_addr),
    .me_wr_line  (me_wr_line),
    .me_rd_line  (me_rd_line),
    .me_rd_valid (me_rd_valid),
    .me_tx_done  (me_tx_done),
    .ready       (ready),
    .tx_done     (tx_done),
    .rd_valid    (rd_valid),
    .rd_line     (rd_line),
    .op          (op),
    .addr        (addr),
    .wr_line     (wr_line)
  );

  // ******************************
  // Memory controller
  // ******************************

  mem_ctrl i_mem_ctrl (
    .clk         (clk),
    .reset       (reset),
    .enable      (enable),
    .base_addr   (base_addr),
    .op          (op),
    .addr        (addr),
    .wr_line     (wr_line),
    .ready       (ready),
    .rd_line     (rd_line),
    .rd_valid    (rd_valid),
    .tx_done     (tx_done),
    .dma_empty   (dma_empty),
    .dma_full    (dma_full),
    .dma_rd_data (dma_rd_data),
    .dma_rd_go   (dma_rd_go),
    .dma_wr_go   (dma_wr_go),
    .dma_rd_en   (dma_rd_en),
    .dma_wr_en   (dma_wr_en),
    .dma_rd_addr (dma_rd_addr),
    .dma_wr_addr (dma_wr_addr),
    .dma_wr_data (dma_wr_data)
  );

endmodule

`default_nettype wire

/* sim/tb_fpu_afu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpu_afu_settings.svh"

module tb_fpu_afu;

  import mem_pkg::*;

  localparam int TIMEOUT = 200;
  localparam int COLS = 6;
  localparam logic [63:0] BASE = 64'h0000_0012_3400_0000;

  logic clk;
  logic reset;
  logic mmio_wr_en;
  logic mmio_rd_en;
  logic mmio_rd_valid;
  logic [`MMIO_ADDR_BITS-1:0] mmio_addr;
  logic [`MMIO_DATA_BITS-1:0] mmio_wr_data;
  logic [`MMIO_DATA_BITS-1:0] mmio_rd_data;
  mem_op_e fe_op;
  mem_op_e me_op;
  logic [`CPU_ADDR_BITS-1:0] fe_addr;
  logic [`CPU_ADDR_BITS-1:0] me_addr;
  logic [`LINE_BITS-1:0] fe_wr_line;
  logic [`LINE_BITS-1:0] fe_rd_line;
  logic [`LINE_BITS-1:0] me_wr_line;
  logic [`LINE_BITS-1:0] me_rd_line;
  logic fe_rd_valid;
  logic fe_tx_done;
  logic me_rd_valid;
  logic me_tx_done;
  logic dma_empty;
  logic dma_full;
  logic dma_rd_go;
  logic dma_wr_go;
  logic dma_rd_en;
  logic dma_wr_en;
  logic [`LINE_BITS-1:0] dma_rd_data;
  logic [`LINE_BITS-1:0] dma_wr_data;
  logic [`HOST_ADDR_BITS-1:0] dma_rd_addr;
  logic [`HOST_ADDR_BITS-1:0] dma_wr_addr;

  // Host memory keyed by byte address of the line
  logic [`LINE_BITS-1:0] host_mem [logic [63:0]];
  // Golden rows, COLS words per transaction
  logic [`LINE_BITS-1:0] gold [0:16*COLS-1];
  int errors;
  bit go_written;
  // Source that completed most recently, fetch gets the first tie
  bit last_served;
  // DMA strobes seen since the current golden rows were issued
  int rd_gos;
  int wr_gos;
  int rd_pops;
  int wr_pushes;

  fpu_afu_top i_fpu_afu_top (
    .clk(clk), .reset(reset),
    .mmio_wr_en(mmio_wr_en), .mmio_rd_en(mmio_rd_en), .mmio_addr(mmio_addr),
    .mmio_wr_data(mmio_wr_data), .mmio_rd_data(mmio_rd_data),
    .mmio_rd_valid(mmio_rd_valid),
    .fe_op(fe_op), .fe_addr(fe_addr), .fe_wr_line(fe_wr_line),
    .fe_rd_line(fe_rd_line), .fe_rd_valid(fe_rd_valid), .fe_tx_done(fe_tx_done),
    .me_op(me_op), .me_addr(me_addr), .me_wr_line(me_wr_line),
    .me_rd_line(me_rd_line), .me_rd_valid(me_rd_valid), .me_tx_done(me_tx_done),
    .dma_empty(dma_empty), .dma_full(dma_full), .dma_rd_data(dma_rd_data),
    .dma_rd_go(dma_rd_go), .dma_wr_go(dma_wr_go), .dma_rd_en(dma_rd_en),
    .dma_wr_en(dma_wr_en), .dma_rd_addr(dma_rd_addr), .dma_wr_addr(dma_wr_addr),
    .dma_wr_data(dma_wr_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ******************************
  // Helpers
  // ******************************

  task automatic compare(input string name, input logic [`LINE_BITS-1:0] got,
                         input logic [`LINE_BITS-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  // A line offset becomes a byte offset of 64 bytes per line
  function automatic logic [63:0] line_addr(input logic [31:0] off);
    return BASE + ({32'd0, off} << 6);
  endfunction

  task automatic mmio_write(input logic [15:0] a, input logic [63:0] d);
    @(negedge clk);
    mmio_wr_en = 1'b1;
    mmio_addr = a;
    mmio_wr_data = d;
    @(negedge clk);
    mmio_wr_en = 1'b0;
    if (a == `REG_GO) go_written = 1'b1;
  endtask

  // Data must show up exactly one cycle after the read strobe
  task automatic mmio_read(input logic [15:0] a, input logic [63:0] exp, input string name);
    @(negedge clk);
    mmio_rd_en = 1'b1;
    mmio_addr = a;
    @(negedge clk);
    mmio_rd_en = 1'b0;
    compare("mmio_rd_valid", mmio_rd_valid, 1'b1);
    compare(name, mmio_rd_data, exp);
    @(negedge clk);
    compare("mmio_rd_valid", mmio_rd_valid, 1'b0);
  endtask

  task automatic drive_port(input bit src, input mem_op_e op, input logic [31:0] off,
                            input logic [`LINE_BITS-1:0] line);
    if (src) begin
      me_op = op;
      me_addr = off;
      me_wr_line = line;
    end else begin
      fe_op = op;
      fe_addr = off;
      fe_wr_line = line;
    end
  endtask

  // Called in the cycle where the port sees its own tx_done
  task automatic check_response(input bit src, input mem_op_e op,
                                input logic [`LINE_BITS-1:0] line);
    logic vld;
    logic oth_done;
    logic oth_vld;
    logic [`LINE_BITS-1:0] got;
    vld = src ? me_rd_valid : fe_rd_valid;
    got = src ? me_rd_line : fe_rd_line;
    oth_done = src ? fe_tx_done : me_tx_done;
    oth_vld = src ? fe_rd_valid : me_rd_valid;
    compare(src ? "me_rd_valid" : "fe_rd_valid", vld, op == mem_read);
    if (op == mem_read) compare(src ? "me_rd_line" : "fe_rd_line", got, line);
    compare(src ? "fe_tx_done" : "me_tx_done", oth_done, 1'b0);
    compare(src ? "fe_rd_valid" : "me_rd_valid", oth_vld, 1'b0);
    last_served = src;
    drive_port(src, mem_idle, '0, '0);
  endtask

  // Runs one row alone, or a fetch row and a data row together
  task automatic run_rows(input int r, input bit pair);
    int cyc;
    bit fe_busy;
    bit me_busy;
    bit first;
    int exp_rd;
    int exp_wr;
    fe_busy = 1'b0;
    me_busy = 1'b0;
    first = ~last_served;
    exp_rd = 0;
    exp_wr = 0;
    rd_gos = 0;
    wr_gos = 0;
    rd_pops = 0;
    wr_pushes = 0;
    for (int k = 0; k <= int'(pair); k++) begin
      drive_port(gold[(r+k)*COLS+1][0], mem_op_e'(gold[(r+k)*COLS+2][1:0]),
                 gold[(r+k)*COLS+3][31:0], gold[(r+k)*COLS+4]);
      if (gold[(r+k)*COLS+1][0]) me_busy = 1'b1;
      else fe_busy = 1'b1;
      if (gold[(r+k)*COLS+2][1:0] == mem_read) exp_rd++;
      else exp_wr++;
    end
    cyc = 0;
    while ((fe_busy || me_busy) && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
      if (fe_busy && fe_tx_done) begin
        if (pair && me_busy) compare("first grant", 1'b0, first);
        check_response(1'b0, fe_op, gold[r*COLS+4]);
        fe_busy = 1'b0;
      end
      if (me_busy && me_tx_done) begin
        if (pair && fe_busy) compare("first grant", 1'b1, first);
        check_response(1'b1, me_op, gold[(r+int'(pair))*COLS+4]);
        me_busy = 1'b0;
      end
    end
    if (fe_busy || me_busy) begin
      errors++;
      $display("Timed out waiting for tx_done of golden row %0d", r);
      drive_port(1'b0, mem_idle, '0, '0);
      drive_port(1'b1, mem_idle, '0, '0);
    end
    // Each read starts and pops once, each write starts and pushes once
    compare("dma_rd_go pulses", rd_gos, exp_rd);
    compare("dma_rd_en pulses", rd_pops, exp_rd);
    compare("dma_wr_go pulses", wr_gos, exp_wr);
    compare("dma_wr_en pulses", wr_pushes, exp_wr);
  endtask

  // ******************************
  // Host DMA model
  // ******************************

  // Random FIFO stalls, and the read FIFO head follows the current address
  always @(negedge clk) begin
    if (reset) begin
      dma_empty = 1'b1;
      dma_full = 1'b1;
    end else begin
      dma_empty = ($urandom % 3) == 0;
      dma_full = ($urandom % 3) == 0;
    end
    dma_rd_data = host_mem.exists(dma_rd_addr) ? host_mem[dma_rd_addr] : '0;
  end

  always @(posedge clk) begin
    if (!reset) begin
      if ((dma_rd_go || dma_wr_go) && !go_written) begin
        errors++;
        $display("DMA channel started before software wrote the go register");
      end
      if (dma_rd_go) rd_gos++;
      if (dma_wr_go) wr_gos++;
      if (dma_rd_go && !((fe_op == mem_read && dma_rd_addr == line_addr(fe_addr)) ||
                         (me_op == mem_read && dma_rd_addr == line_addr(me_addr)))) begin
        errors++;
        $display("Read address %h matches no pending read request", dma_rd_addr);
      end
      if (dma_rd_en) begin
        rd_pops++;
        if (dma_empty) begin
          errors++;
          $display("Read FIFO was popped while it was empty");
        end
      end
      if (dma_wr_en) begin
        wr_pushes++;
        if (dma_full) begin
          errors++;
          $display("Write FIFO was pushed while it was full");
        end
        if (me_op == mem_write && dma_wr_addr == line_addr(me_addr)) begin
          compare("dma_wr_data", dma_wr_data, me_wr_line);
        end else if (fe_op == mem_write && dma_wr_addr == line_addr(fe_addr)) begin
          compare("dma_wr_data", dma_wr_data, fe_wr_line);
        end else begin
          errors++;
          $display("Write address %h matches no pending write request", dma_wr_addr);
        end
        host_mem[dma_wr_addr] = dma_wr_data;
      end
    end
  end

  // ******************************
  // Main sequence
  // ******************************

  initial begin
    int r;
    void'($urandom(12562));
    errors = 0;
    go_written = 1'b0;
    last_served = 1'b1;
    reset = 1'b1;
    mmio_wr_en = 1'b0;
    mmio_rd_en = 1'b0;
    mmio_addr = '0;
    mmio_wr_data = '0;
    drive_port(1'b0, mem_idle, '0, '0);
    drive_port(1'b1, mem_idle, '0, '0);
    dma_empty = 1'b1;
    dma_full = 1'b1;
    dma_rd_data = '0;
    for (int i = 0; i < 16*COLS; i++) gold[i] = '0;
    $readmemh("sim/fpu_afu_golden.txt", gold);

    repeat (2) @(negedge clk);
    reset = 1'b0;

    mmio_read(`REG_ID_LO, `AFU_ID_LO, "mmio_rd_data id_lo");
    mmio_read(`REG_ID_HI, `AFU_ID_HI, "mmio_rd_data id_hi");

    // A request before go must not start any DMA channel
    drive_port(1'b1, mem_write, 32'd1, '1);
    repeat (8) @(negedge clk);
    drive_port(1'b1, mem_idle, '0, '0);

    mmio_write(`REG_BASE, BASE);
    mmio_write(`REG_GO, 64'd1);

    r = 0;
    while (gold[r*COLS+2] != '0 && r < 16) begin
      run_rows(r, gold[r*COLS][0]);
      r = r + 1 + int'(gold[r*COLS][0]);
      mmio_read(`REG_COUNT, gold[(r-1)*COLS+5][63:0], "mmio_rd_data count");
    end

    $display("Golden rows run: %0d, errors: %0d", r, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* fpu_afu.f */
+incdir+hdl
hdl/mem_pkg.sv
hdl/mmio_pkg.sv
hdl/mmio_regs.sv
hdl/mem_arbiter.sv
hdl/mem_ctrl.sv
hdl/fpu_afu_top.sv
sim/tb_fpu_afu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fpu_afu testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --assert -Wno-fatal -j 0 \
  --top-module tb_fpu_afu -f fpu_afu.f -o sim_fpu_afu > build.log 2>&1 &&
  ./obj_dir/sim_fpu_afu > sim.log 2>&1 ||
  { echo "Build or simulation aborted, see build.log and sim.log"; exit 1; }

cat sim.log

grep -q "Errors found" sim.log && { echo "Simulation FAILED"; exit 1; } ||
  { echo "Simulation PASSED"; exit 0; }

/* sim/fpu_afu_golden.txt */
// Columns: pair src op offset line count, all hex
// pair=1 issues this fetch row together with the next data row, src 0=fetch 1=data, op 1=read 2=write
0 1 2 5 0123456789abcdef0fedcba987654321 1
0 0 1 5 0123456789abcdef0fedcba987654321 2
0 1 2 10 deadbeef00112233445566778899aabb 3
0 0 2 22 cafef00d13572468acebdf0197531864 4
1 0 1 10 deadbeef00112233445566778899aabb 6
0 1 1 22 cafef00d13572468acebdf0197531864 6
0 1 2 7 f0e1d2c3b4a5968778695a4b3c2d1e0f 7
0 0 1 7 f0e1d2c3b4a5968778695a4b3c2d1e0f 8
1 0 2 30 11112222333344445555666677778888 a
0 1 2 31 99990000aaaabbbbccccddddeeeeffff a
1 0 1 31 99990000aaaabbbbccccddddeeeeffff c
0 1 1 30 11112222333344445555666677778888 c
0 1 1 5 0123456789abcdef0fedcba987654321 d
